/* hw/xg_mac_rx_pkg.sv */
`default_nettype none

package xg_mac_rx_pkg;

	//////////////////////////////////////////////////////////////////////
	// XGMII control characters

	localparam logic [7:0] XGMII_CTL_START = 8'hfb;
	localparam logic [7:0] XGMII_CTL_END   = 8'hfd;
	localparam logic [7:0] XGMII_CTL_ERROR = 8'hfe;
	localparam logic [7:0] XGMII_CTL_IDLE  = 8'h07;

	// Second preamble word, SFD sits in the lowest lane
	localparam logic [31:0] PREAMBLE_SFD_WORD = 32'h555555d5;

	//////////////////////////////////////////////////////////////////////
	// Widths

	localparam int LANES   = 4;
	localparam int BYTE_W  = 8;
	localparam int WORD_W  = 32;
	// Byte count 0..4
	localparam int BYTES_W = 3;
	localparam int CRC_W   = 32;

	//////////////////////////////////////////////////////////////////////
	// Ethernet CRC32, reflected form

	localparam logic [31:0] CRC_POLY   = 32'hedb88320;
	localparam logic [31:0] CRC_INIT   = 32'hffffffff;
	localparam logic [31:0] CRC_XOROUT = 32'hffffffff;

	//////////////////////////////////////////////////////////////////////
	// Types

	// One XGMII word, seen whole or per lane
	// Lane 3 is bits 31:24 and goes first on the wire
	typedef union packed {
		logic [WORD_W-1:0]             word;
		logic [LANES-1:0][BYTE_W-1:0]  lanes;
	} xgmii_word_u;

	// Receive frame states
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		PREAMBLE = 2'd1,
		BODY     = 2'd2
	} rx_state_e;

endpackage

`default_nettype wire

/* hw/xgmii_lane_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module xgmii_lane_decode import xg_mac_rx_pkg::*; (
	// One control flag per lane
	input  logic [LANES-1:0] ctl,
	input  xgmii_word_u      data,

	// Per-lane character hits
	output logic [LANES-1:0] lane_end,
	output logic [LANES-1:0] lane_error,

	// Start only counts in lane 3
	output logic             start_seen,
	// Plain data word equal to 55 55 55 D5
	output logic             preamble_ok
);

	//////////////////////////////////////////////////////////////////////
	// Per-lane compares

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			// A data byte that happens to match is not a control char
			lane_end[i]   = ctl[i] && (data.lanes[i] == XGMII_CTL_END);
			lane_error[i] = ctl[i] && (data.lanes[i] == XGMII_CTL_ERROR);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame delimiters

	// Start of frame is always aligned to the leftmost lane
	assign start_seen = ctl[LANES-1] && (data.lanes[LANES-1] == XGMII_CTL_START);

	// Whole-word compare, any control flag spoils it
	assign preamble_ok = (ctl == '0) && (data.word == PREAMBLE_SFD_WORD);

endmodule

`default_nettype wire

/* hw/rx_frame_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_frame_fsm import xg_mac_rx_pkg::*; (
	input  logic             xgmii_rx_clk,
	input  logic             arst_n,

	// Beat qualifier, low means stall
	input  logic             xgmii_rx_valid,

	// From the lane decoder
	input  logic [LANES-1:0] lane_end,
	input  logic [LANES-1:0] lane_error,
	input  logic             start_seen,
	input  logic             preamble_ok,

	// From the FCS compare
	input  logic             fcs_match,

	output logic             body_beat,
	output logic             first_beat,
	output logic             rx_start,
	output logic             rx_commit,
	output logic             rx_drop
);

	rx_state_e state_q;

	// Verdict timer, end beat seen one and two clocks ago
	logic pend_0_q;
	logic pend_1_q;

	logic any_error;

	assign any_error = |lane_error;

	// Payload-carrying beat, error beats carry nothing
	assign body_beat = (state_q == BODY) && xgmii_rx_valid && !any_error;

	//////////////////////////////////////////////////////////////////////
	// State, pulses and verdict timer

	always_ff @(posedge xgmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= IDLE;
			first_beat <= 1'b0;
			rx_start   <= 1'b0;
			rx_commit  <= 1'b0;
			rx_drop    <= 1'b0;
			pend_0_q   <= 1'b0;
			pend_1_q   <= 1'b0;
		end else begin
			rx_start <= 1'b0;

			// Timer runs on every clock so the verdict latency is fixed
			pend_0_q  <= 1'b0;
			pend_1_q  <= pend_0_q;
			rx_commit <= pend_1_q && fcs_match;
			rx_drop   <= pend_1_q && !fcs_match;

			if (xgmii_rx_valid) begin
				// Only the beat right after the SFD is a first beat
				first_beat <= 1'b0;

				case (state_q)
					IDLE: begin
						// Idles and stray errors are ignored here
						if (start_seen) begin
							state_q <= PREAMBLE;
						end
					end

					PREAMBLE: begin
						// Pulse start even if the preamble turns out bad
						rx_start <= 1'b1;
						if (preamble_ok) begin
							state_q    <= BODY;
							first_beat <= 1'b1;
						end else begin
							// Bad preamble, silent return
							state_q <= IDLE;
						end
					end

					BODY: begin
						// End may sit in any lane
						if (|lane_end) begin
							state_q  <= IDLE;
							pend_0_q <= 1'b1;
						end
					end

					default: begin
						state_q <= IDLE;
					end
				endcase

				// Error char inside a frame wins over everything
				if (any_error && (state_q != IDLE)) begin
					state_q    <= IDLE;
					first_beat <= 1'b0;
					rx_commit  <= 1'b0;
					rx_drop    <= 1'b1;
					// Cancel any verdict still in flight
					pend_0_q   <= 1'b0;
					pend_1_q   <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/rx_fcs_align.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_fcs_align import xg_mac_rx_pkg::*; (
	input  logic               xgmii_rx_clk,
	input  logic               arst_n,

	input  xgmii_word_u        xgmii_data,
	input  logic [LANES-1:0]   lane_end,
	input  logic               body_beat,
	input  logic               first_beat,

	// Finalized CRC in wire byte order
	input  logic [CRC_W-1:0]   crc_out,

	output logic [WORD_W-1:0]  rx_data,
	output logic               rx_data_valid,
	output logic [BYTES_W-1:0] rx_bytes_valid,
	output logic               fcs_match
);

	// Previous body word that may still turn out to be FCS
	xgmii_word_u held_q;

	logic [CRC_W-1:0] fcs_exp;
	logic [CRC_W-1:0] fcs_exp_q;

	assign rx_data = held_q.word;

	//////////////////////////////////////////////////////////////////////
	// Bytes valid and FCS splice

	always_comb begin
		rx_bytes_valid = '0;
		fcs_exp        = held_q.word;

		// Nothing from the word that held the SFD
		if (body_beat && !first_beat) begin
			// First end lane on the wire decides how much is FCS
			if (lane_end[3]) begin
				// Held word is all FCS
				fcs_exp = held_q.word;
			end else if (lane_end[2]) begin
				rx_bytes_valid = BYTES_W'(1);
				fcs_exp        = {held_q.lanes[2:0], xgmii_data.lanes[3]};
			end else if (lane_end[1]) begin
				rx_bytes_valid = BYTES_W'(2);
				fcs_exp        = {held_q.lanes[1:0], xgmii_data.lanes[3:2]};
			end else if (lane_end[0]) begin
				rx_bytes_valid = BYTES_W'(3);
				fcs_exp        = {held_q.lanes[0], xgmii_data.lanes[3:1]};
			end else begin
				// Mid-frame the held word is all payload
				rx_bytes_valid = BYTES_W'(LANES);
			end
		end
	end

	assign rx_data_valid = (rx_bytes_valid != '0);

	//////////////////////////////////////////////////////////////////////
	// Word delay

	always_ff @(posedge xgmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			held_q <= '0;
		end else if (body_beat) begin
			held_q <= xgmii_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Expected FCS captured on the end beat

	always_ff @(posedge xgmii_rx_clk) begin
		if (body_beat && (|lane_end)) begin
			fcs_exp_q <= fcs_exp;
		end
	end

	// Valid once crc_out has folded in the last payload bytes
	assign fcs_match = (fcs_exp_q == crc_out);

endmodule

`default_nettype wire

/* hw/crc32_eth_x32.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32_eth_x32 import xg_mac_rx_pkg::*; (
	input  logic               xgmii_rx_clk,
	input  logic               arst_n,

	// Restart at CRC_INIT
	input  logic               clear,
	input  logic               enable,

	// Leading bytes of data to fold, lane 3 first
	input  logic [BYTES_W-1:0] bytes,
	input  logic [WORD_W-1:0]  data,

	output logic [CRC_W-1:0]   crc_out
);

	logic [CRC_W-1:0] crc_q;
	logic [CRC_W-1:0] crc_next;
	logic [CRC_W-1:0] crc_fin;

	// One byte through the reflected polynomial, LSB first
	function automatic logic [CRC_W-1:0] crc_byte(
		input logic [CRC_W-1:0]  crc,
		input logic [BYTE_W-1:0] b
	);
		logic [CRC_W-1:0] c;
		c = crc ^ {{(CRC_W-BYTE_W){1'b0}}, b};
		for (int k = 0; k < BYTE_W; k++) begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Fold 0..4 bytes, lane 3 down

	always_comb begin
		crc_next = crc_q;
		for (int i = 0; i < LANES; i++) begin
			if (i < int'(bytes)) begin
				crc_next = crc_byte(crc_next, data[WORD_W-1-i*BYTE_W -: BYTE_W]);
			end
		end
	end

	assign crc_fin = crc_q ^ CRC_XOROUT;

	//////////////////////////////////////////////////////////////////////
	// Stage 1 running CRC, stage 2 finalized output

	always_ff @(posedge xgmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_q   <= CRC_INIT;
			crc_out <= '0;
		end else begin
			if (clear) begin
				crc_q <= CRC_INIT;
			end else if (enable) begin
				crc_q <= crc_next;
			end
			// FCS goes out low byte first, so swap to lane order
			crc_out <= {crc_fin[7:0], crc_fin[15:8], crc_fin[23:16], crc_fin[31:24]};
		end
	end

endmodule

`default_nettype wire

/* hw/xg_mac_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module xg_mac_rx import xg_mac_rx_pkg::*; (
	input  logic               xgmii_rx_clk,
	input  logic               arst_n,

	// XGMII receive side
	input  logic               xgmii_rx_valid,
	input  logic [LANES-1:0]   xgmii_rx_ctl,
	input  logic [WORD_W-1:0]  xgmii_rx_data,

	// Upper layer stream, act only after rx_commit
	output logic               rx_start,
	output logic [WORD_W-1:0]  rx_data,
	output logic               rx_data_valid,
	output logic [BYTES_W-1:0] rx_bytes_valid,
	output logic               rx_commit,
	output logic               rx_drop
);

	logic [LANES-1:0] lane_end;
	logic [LANES-1:0] lane_error;
	logic             start_seen;
	logic             preamble_ok;
	logic             body_beat;
	logic             first_beat;
	logic             fcs_match;
	logic [CRC_W-1:0] crc_out;

	//////////////////////////////////////////////////////////////////////
	// Control character decode

	xgmii_lane_decode u_decode (
		.ctl         (xgmii_rx_ctl),
		.data        (xgmii_rx_data),
		.lane_end    (lane_end),
		.lane_error  (lane_error),
		.start_seen  (start_seen),
		.preamble_ok (preamble_ok)
	);

	//////////////////////////////////////////////////////////////////////
	// Frame tracking and verdict

	rx_frame_fsm u_fsm (
		.xgmii_rx_clk   (xgmii_rx_clk),
		.arst_n         (arst_n),
		.xgmii_rx_valid (xgmii_rx_valid),
		.lane_end       (lane_end),
		.lane_error     (lane_error),
		.start_seen     (start_seen),
		.preamble_ok    (preamble_ok),
		.fcs_match      (fcs_match),
		.body_beat      (body_beat),
		.first_beat     (first_beat),
		.rx_start       (rx_start),
		.rx_commit      (rx_commit),
		.rx_drop        (rx_drop)
	);

	//////////////////////////////////////////////////////////////////////
	// Payload delay and FCS strip

	rx_fcs_align u_align (
		.xgmii_rx_clk   (xgmii_rx_clk),
		.arst_n         (arst_n),
		.xgmii_data     (xgmii_rx_data),
		.lane_end       (lane_end),
		.body_beat      (body_beat),
		.first_beat     (first_beat),
		.crc_out        (crc_out),
		.rx_data        (rx_data),
		.rx_data_valid  (rx_data_valid),
		.rx_bytes_valid (rx_bytes_valid),
		.fcs_match      (fcs_match)
	);

	// CRC sees exactly the emitted payload bytes
	crc32_eth_x32 u_crc (
		.xgmii_rx_clk (xgmii_rx_clk),
		.arst_n       (arst_n),
		.clear        (rx_start),
		.enable       (rx_data_valid),
		.bytes        (rx_bytes_valid),
		.data         (rx_data),
		.crc_out      (crc_out)
	);

endmodule

`default_nettype wire

/* dv/tb_xg_mac_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_xg_mac_rx import xg_mac_rx_pkg::*; ();

	// Frame kinds for the builder
	localparam int MODE_GOOD    = 0;
	localparam int MODE_BAD_FCS = 1;
	localparam int MODE_ERROR   = 2;
	localparam int MODE_BAD_PRE = 3;

	// Longest frame is 100 payload + 4 FCS + 8 preamble bytes
	localparam int N_FRAMES        = 24;
	localparam int MAX_LEN         = 112;
	localparam int WATCHDOG_CYCLES = N_FRAMES * (MAX_LEN / 4 + 20) + 100;

	logic        xgmii_rx_clk;
	logic        arst_n;
	logic        xgmii_rx_valid;
	logic [3:0]  xgmii_rx_ctl;
	logic [31:0] xgmii_rx_data;
	logic        rx_start;
	logic [31:0] rx_data;
	logic        rx_data_valid;
	logic [2:0]  rx_bytes_valid;
	logic        rx_commit;
	logic        rx_drop;

	// Expected verdicts in frame order with the bytes kept flat
	logic        exp_ok[$];
	int          exp_len[$];
	logic [7:0]  exp_bytes[$];
	logic [7:0]  got_bytes[$];

	int err_count;
	int start_count;
	int dv_count;
	int verdict_count;
	int pass_tests;
	int fail_tests;
	int err_mark;
	int start_mark;
	// Percent chance of a stall cycle before each word
	int stall_pct;

	xg_mac_rx u_dut (
		.xgmii_rx_clk   (xgmii_rx_clk),
		.arst_n         (arst_n),
		.xgmii_rx_valid (xgmii_rx_valid),
		.xgmii_rx_ctl   (xgmii_rx_ctl),
		.xgmii_rx_data  (xgmii_rx_data),
		.rx_start       (rx_start),
		.rx_data        (rx_data),
		.rx_data_valid  (rx_data_valid),
		.rx_bytes_valid (rx_bytes_valid),
		.rx_commit      (rx_commit),
		.rx_drop        (rx_drop)
	);

	initial begin
		xgmii_rx_clk = 1'b0;
		forever #5 xgmii_rx_clk = ~xgmii_rx_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference Ethernet CRC32 over the payload giving the FCS as sent

	function automatic logic [31:0] fcs_of(input logic [7:0] bytes_q[$]);
		logic [31:0] c;
		c = 32'hffffffff;
		foreach (bytes_q[i]) begin
			c = c ^ {24'h0, bytes_q[i]};
			// Reflected polynomial one bit per step
			for (int k = 0; k < 8; k++) begin
				c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
			end
		end
		return ~c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic send_word(input logic [3:0] c, input logic [31:0] d);
		// Optional stall with junk on the bus
		if (stall_pct > 0 && int'($urandom % 100) < stall_pct) begin
			@(posedge xgmii_rx_clk);
			xgmii_rx_valid <= 1'b0;
			xgmii_rx_ctl   <= 4'($urandom);
			xgmii_rx_data  <= $urandom;
		end
		@(posedge xgmii_rx_clk);
		xgmii_rx_valid <= 1'b1;
		xgmii_rx_ctl   <= c;
		xgmii_rx_data  <= d;
	endtask

	task automatic send_frame(input int len, input int mode, input int gap);
		logic [7:0]  payload[$];
		logic [7:0]  wire_q[$];
		logic [31:0] fcs;
		logic [31:0] w;
		logic [3:0]  c;
		int          err_word;
		int          n_emit;
		int          k;
		for (int i = 0; i < len; i++) begin
			payload.push_back(8'($urandom));
		end
		fcs = fcs_of(payload);
		if (mode == MODE_BAD_FCS) begin
			fcs = fcs ^ (32'h1 << ($urandom % 32));
		end
		// FCS goes out low byte first
		wire_q = payload;
		wire_q.push_back(fcs[7:0]);
		wire_q.push_back(fcs[15:8]);
		wire_q.push_back(fcs[23:16]);
		wire_q.push_back(fcs[31:24]);
		// Error word index among body words from 2 on
		err_word = 2 + int'($urandom % (len / 4 - 2));
		// Body is delayed one beat and the error beat carries nothing
		n_emit = (mode == MODE_ERROR) ? 4 * (err_word - 1) : len;
		if (mode != MODE_BAD_PRE) begin
			exp_ok.push_back(mode == MODE_GOOD);
			exp_len.push_back(n_emit);
			for (int i = 0; i < n_emit; i++) begin
				exp_bytes.push_back(payload[i]);
			end
		end
		send_word(4'b1000, {XGMII_CTL_START, 24'h555555});
		send_word(4'b0000, (mode == MODE_BAD_PRE) ? 32'h555555d4 : PREAMBLE_SFD_WORD);
		// Lane 3 first with the end char right after the last FCS byte
		for (int wi = 0; wi < (len + 8) / 4; wi++) begin
			c = 4'b0000;
			w = '0;
			for (int l = 0; l < 4; l++) begin
				k = wi * 4 + l;
				if (k < wire_q.size()) begin
					w[31-8*l -: 8] = wire_q[k];
				end else begin
					c[3-l]         = 1'b1;
					w[31-8*l -: 8] = (k == wire_q.size()) ? XGMII_CTL_END : XGMII_CTL_IDLE;
				end
			end
			if (mode == MODE_ERROR && wi == err_word) begin
				c = 4'b1111;
				w = {4{XGMII_CTL_ERROR}};
			end
			send_word(c, w);
		end
		repeat (gap) send_word(4'b1111, {4{XGMII_CTL_IDLE}});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparator on the falling edge where outputs have settled

	always @(negedge xgmii_rx_clk) begin : compare
		logic       want_ok;
		logic [7:0] want;
		int         n;
		if (arst_n) begin
			if (rx_data_valid) begin
				dv_count++;
				for (int i = 0; i < int'(rx_bytes_valid); i++) begin
					got_bytes.push_back(rx_data[31-8*i -: 8]);
				end
			end
			if (rx_start) begin
				start_count++;
			end
			if (rx_commit && rx_drop) begin
				$display("Commit and drop pulsed in the same cycle at %0t", $time);
				err_count++;
			end
			if (rx_commit || rx_drop) begin
				verdict_count++;
				if (exp_ok.size() == 0) begin
					$display("Verdict at %0t with no frame pending", $time);
					err_count++;
				end else begin
					want_ok = exp_ok.pop_front();
					n       = exp_len.pop_front();
					if (rx_commit != want_ok) begin
						$display("ERROR t=%0t rx_commit got %0b expected %0b",
							$time, rx_commit, want_ok);
						err_count++;
					end
					if (got_bytes.size() != n) begin
						$display("ERROR t=%0t rx_bytes_valid total got %0d expected %0d",
							$time, got_bytes.size(), n);
						err_count++;
					end
					for (int i = 0; i < n; i++) begin
						want = exp_bytes.pop_front();
						if (i < got_bytes.size() && got_bytes[i] != want) begin
							$display("ERROR t=%0t rx_data byte %0d got %02h expected %02h",
								$time, i, got_bytes[i], want);
							err_count++;
						end
					end
				end
				got_bytes.delete();
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test bookkeeping

	task automatic start_test();
		err_mark   = err_count;
		start_mark = start_count;
	endtask

	task automatic finish_test(input string name, input int frames);
		int t;
		t = 0;
		while (exp_ok.size() != 0 && t < 200) begin
			@(posedge xgmii_rx_clk);
			t++;
		end
		if (exp_ok.size() != 0) begin
			$display("Verdict never arrived, %0d frame(s) left pending", exp_ok.size());
			err_count++;
			exp_ok.delete();
			exp_len.delete();
			exp_bytes.delete();
		end
		// Room for any stray pulse
		repeat (6) @(posedge xgmii_rx_clk);
		if (start_count - start_mark != frames) begin
			$display("ERROR t=%0t rx_start pulses got %0d expected %0d",
				$time, start_count - start_mark, frames);
			err_count++;
		end
		if (err_count == err_mark) begin
			pass_tests++;
			$display("Test %s: passed", name);
		end else begin
			fail_tests++;
			$display("Test %s: failed with %0d error(s)", name, err_count - err_mark);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int dv_mark;
		int verdict_mark;
		void'($urandom(32'h41a9));
		err_count      = 0;
		start_count    = 0;
		dv_count       = 0;
		verdict_count  = 0;
		pass_tests     = 0;
		fail_tests     = 0;
		stall_pct      = 0;
		arst_n         <= 1'b0;
		xgmii_rx_valid <= 1'b0;
		xgmii_rx_ctl   <= 4'b1111;
		xgmii_rx_data  <= {4{XGMII_CTL_IDLE}};
		repeat (4) @(posedge xgmii_rx_clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge xgmii_rx_clk);

		// Lengths step through every residue mod 4 to hit every end lane
		start_test();
		for (int i = 0; i < 8; i++) begin
			send_frame(60 + 4 * int'($urandom % 10) + i % 4, MODE_GOOD, 4);
		end
		finish_test("good frames in all end lanes", 8);

		start_test();
		send_frame(60 + int'($urandom % 41), MODE_BAD_FCS, 4);
		send_frame(60 + int'($urandom % 41), MODE_BAD_FCS, 4);
		finish_test("corrupted FCS", 2);

		start_test();
		send_frame(60 + int'($urandom % 41), MODE_ERROR, 4);
		send_frame(60 + int'($urandom % 41), MODE_GOOD, 4);
		finish_test("error char mid-body", 2);

		// Bad preamble must stay silent apart from rx_start
		start_test();
		dv_mark      = dv_count;
		verdict_mark = verdict_count;
		send_frame(60 + int'($urandom % 41), MODE_BAD_PRE, 4);
		repeat (8) @(posedge xgmii_rx_clk);
		if (dv_count != dv_mark) begin
			$display("ERROR t=%0t rx_data_valid beats got %0d expected 0",
				$time, dv_count - dv_mark);
			err_count++;
		end
		if (verdict_count != verdict_mark) begin
			$display("ERROR t=%0t rx_commit/rx_drop pulses got %0d expected 0",
				$time, verdict_count - verdict_mark);
			err_count++;
		end
		send_frame(60 + int'($urandom % 41), MODE_GOOD, 4);
		finish_test("bad preamble", 2);

		start_test();
		stall_pct = 25;
		for (int i = 0; i < 4; i++) begin
			send_frame(60 + int'($urandom % 41), MODE_GOOD, 4);
		end
		stall_pct = 0;
		finish_test("input stalls", 4);

		// End word followed straight by the next start
		start_test();
		send_frame(60 + int'($urandom % 41), MODE_GOOD, 0);
		send_frame(60 + int'($urandom % 41), MODE_BAD_FCS, 0);
		send_frame(60 + int'($urandom % 41), MODE_GOOD, 0);
		send_frame(60 + int'($urandom % 41), MODE_ERROR, 0);
		send_frame(60 + int'($urandom % 41), MODE_GOOD, 0);
		send_frame(60 + int'($urandom % 41), MODE_GOOD, 4);
		finish_test("back-to-back frames", 6);

		$display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
		if (err_count == 0 && fail_tests == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog sized from the frame count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge xgmii_rx_clk);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hw/xg_mac_rx_pkg.sv
hw/xgmii_lane_decode.sv
hw/rx_frame_fsm.sv
hw/rx_fcs_align.sv
hw/crc32_eth_x32.sv
hw/xg_mac_rx.sv
dv/tb_xg_mac_rx.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_xg_mac_rx
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
